// ==== bpb_if.sv ====
`timescale 1ns/1ps

interface bpb_if;
    import fetch_pkg::*;

    // lookup addresses, pc_b is pc_a plus 4
    logic [WORD_W-1:0] pc_a;
    logic [WORD_W-1:0] pc_b;

    // combinational lookup results
    logic              taken_a;
    logic              taken_b;
    logic [WORD_W-1:0] target_a;
    logic [WORD_W-1:0] target_b;

    // resolved branch from later stages
    logic              upd_valid;
    logic [WORD_W-1:0] upd_pc;
    logic              upd_taken;
    logic [WORD_W-1:0] upd_target;

    modport fetcher (
        output pc_a,
        output pc_b,
        input  taken_a,
        input  taken_b,
        input  target_a,
        input  target_b
    );

    modport predictor (
        input  pc_a,
        input  pc_b,
        output taken_a,
        output taken_b,
        output target_a,
        output target_b,
        input  upd_valid,
        input  upd_pc,
        input  upd_taken,
        input  upd_target
    );

endinterface

// ==== branch_pred_buffer.sv ====
`timescale 1ns/1ps

module branch_pred_buffer #(
    parameter int BPB_ENTRIES = 16
) (
    input logic        clk,
    input logic        reset,
    bpb_if.predictor   bp
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(BPB_ENTRIES);
    localparam int TAG_W = WORD_W - 2 - IDX_W;

    logic [BPB_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]       tag_mem    [BPB_ENTRIES];
    logic [WORD_W-1:0]      target_mem [BPB_ENTRIES];
    logic [CNT_W-1:0]       cnt_mem    [BPB_ENTRIES];

    logic [IDX_W-1:0]       idx_a;
    logic [IDX_W-1:0]       idx_b;
    logic [IDX_W-1:0]       upd_idx;
    logic                   upd_hit;
    logic [CNT_W-1:0]       upd_cnt;

    function automatic logic [IDX_W-1:0] index_of(input logic [WORD_W-1:0] addr);
        return addr[2 +: IDX_W];
    endfunction

    function automatic logic [TAG_W-1:0] tag_of(input logic [WORD_W-1:0] addr);
        return addr[WORD_W-1 -: TAG_W];
    endfunction

    assign idx_a   = index_of(bp.pc_a);
    assign idx_b   = index_of(bp.pc_b);
    assign upd_idx = index_of(bp.upd_pc);

    // two independent read ports on the same table
    assign bp.taken_a = valid[idx_a] && (tag_mem[idx_a] == tag_of(bp.pc_a))
                        && (cnt_mem[idx_a] >= CNT_TAKEN_MIN);
    assign bp.taken_b = valid[idx_b] && (tag_mem[idx_b] == tag_of(bp.pc_b))
                        && (cnt_mem[idx_b] >= CNT_TAKEN_MIN);
    assign bp.target_a = target_mem[idx_a];
    assign bp.target_b = target_mem[idx_b];

    assign upd_hit = valid[upd_idx] && (tag_mem[upd_idx] == tag_of(bp.upd_pc));

    always_comb
    begin
        if (!upd_hit)
        begin
            // fresh entry starts weak in the resolved direction
            upd_cnt = bp.upd_taken ? CNT_TAKEN_MIN : CNT_WEAK_NT;
        end
        else if (bp.upd_taken)
        begin
            upd_cnt = (cnt_mem[upd_idx] == CNT_MAX) ? CNT_MAX : cnt_mem[upd_idx] + 1'b1;
        end
        else
        begin
            upd_cnt = (cnt_mem[upd_idx] == CNT_MIN) ? CNT_MIN : cnt_mem[upd_idx] - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            valid <= '0;
        else if (bp.upd_valid)
            valid[upd_idx] <= 1'b1;
    end

    // lookups this cycle still see the old entry
    always_ff @(posedge clk)
    begin
        if (bp.upd_valid)
        begin
            tag_mem[upd_idx]    <= tag_of(bp.upd_pc);
            target_mem[upd_idx] <= bp.upd_target;
            cnt_mem[upd_idx]    <= upd_cnt;
        end
    end

    a_upd_known: assert property (@(posedge clk) disable iff (reset)
        bp.upd_valid |-> !$isunknown({bp.upd_pc, bp.upd_taken, bp.upd_target}));

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

    // instruction and address width
    localparam int WORD_W = 32;

    // boot vector
    localparam logic [WORD_W-1:0] RESET_PC = 32'hbfc00000;

    // 2-bit saturating predictor counters
    localparam int CNT_W = 2;

    // counter value from which a branch is predicted taken
    localparam logic [CNT_W-1:0] CNT_TAKEN_MIN = 2'd2;

    // weakly not taken, used when a not-taken branch is allocated
    localparam logic [CNT_W-1:0] CNT_WEAK_NT = CNT_TAKEN_MIN - 2'd1;

    // saturation limits
    localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};
    localparam logic [CNT_W-1:0] CNT_MIN = '0;

    // pc step per instruction and per pair
    localparam logic [WORD_W-1:0] PC_STEP_ONE = 32'd4;
    localparam logic [WORD_W-1:0] PC_STEP_TWO = 32'd8;

endpackage

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          exc_valid,
    input  logic [fetch_pkg::WORD_W-1:0]  exc_pc,
    input  logic                          eret,
    input  logic [fetch_pkg::WORD_W-1:0]  epc,
    input  logic                          branch_taken,
    input  logic [fetch_pkg::WORD_W-1:0]  branch_pc,
    input  logic                          jump,
    input  logic [fetch_pkg::WORD_W-1:0]  jump_pc,
    input  logic                          jr,
    input  logic [fetch_pkg::WORD_W-1:0]  jr_pc,
    imem_if.fetcher                       mem,
    bpb_if.fetcher                        bp,
    output logic [fetch_pkg::WORD_W-1:0]  pc,
    output logic                          out_valid,
    output logic [fetch_pkg::WORD_W-1:0]  slot_a_instr,
    output logic [fetch_pkg::WORD_W-1:0]  slot_a_pcplus4,
    output logic                          slot_a_pred,
    output logic                          slot_b_valid,
    output logic [fetch_pkg::WORD_W-1:0]  slot_b_instr,
    output logic [fetch_pkg::WORD_W-1:0]  slot_b_pcplus4,
    output logic                          slot_b_pred,
    output logic                          misaligned
);
    import fetch_pkg::*;

    logic              conflict;
    logic              pred_taken_q;
    logic [WORD_W-1:0] pred_target_q;
    logic              redirect;
    logic [WORD_W-1:0] redirect_pc;
    logic [WORD_W-1:0] pc_plus4;
    logic [WORD_W-1:0] pc_plus8;
    logic [WORD_W-1:0] next_pc;
    logic              next_pred_taken;
    logic [WORD_W-1:0] next_pred_target;

    // exception first, jr last
    always_comb
    begin
        redirect    = 1'b1;
        redirect_pc = exc_pc;
        if (exc_valid)
            redirect_pc = exc_pc;
        else if (eret)
            redirect_pc = epc;
        else if (branch_taken)
            redirect_pc = branch_pc;
        else if (jump)
            redirect_pc = jump_pc;
        else if (jr)
            redirect_pc = jr_pc;
        else
            redirect = 1'b0;
    end

    assign pc_plus4 = pc + PC_STEP_ONE;
    assign pc_plus8 = pc + PC_STEP_TWO;

    assign mem.addr = pc;
    assign bp.pc_a  = pc;
    assign bp.pc_b  = pc_plus4;

    // a predicted-taken pair ends at slot a, its delay slot
    assign slot_b_valid = mem.second_ok & ~pred_taken_q;

    // stale responses are drained even under stall
    assign out_valid  = mem.data_ok & ~conflict & ~stall & ~redirect;
    assign mem.accept = mem.data_ok & (conflict | (~stall & ~redirect));

    always_comb
    begin
        if (pred_taken_q)
        begin
            next_pc          = pred_target_q;
            next_pred_taken  = 1'b0;
            next_pred_target = '0;
        end
        else
        begin
            if (slot_b_valid && bp.taken_a)
                next_pc = bp.target_a;
            else if (slot_b_valid)
                next_pc = pc_plus8;
            else
                next_pc = pc_plus4;

            // remember whatever the last valid slot predicted
            next_pred_taken  = slot_b_valid ? bp.taken_b : bp.taken_a;
            next_pred_target = slot_b_valid ? bp.target_b : bp.target_a;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pc            <= RESET_PC;
            pred_taken_q  <= 1'b0;
            pred_target_q <= '0;
            conflict      <= 1'b0;
        end
        else
        begin
            if (redirect)
            begin
                pc            <= redirect_pc;
                pred_taken_q  <= 1'b0;
                pred_target_q <= '0;
            end
            else if (out_valid)
            begin
                pc            <= next_pc;
                pred_taken_q  <= next_pred_taken;
                pred_target_q <= next_pred_target;
            end

            // old request still outstanding unless it leaves this cycle
            if (redirect)
                conflict <= ~mem.accept;
            else if (mem.accept)
                conflict <= 1'b0;
        end
    end

    assign slot_a_instr   = mem.data_a;
    assign slot_a_pcplus4 = pc_plus4;
    assign slot_a_pred    = bp.taken_a;
    assign slot_b_instr   = mem.data_b;
    assign slot_b_pcplus4 = pc_plus8;
    assign slot_b_pred    = bp.taken_b & slot_b_valid;
    assign misaligned     = (pc[1:0] != 2'b00);

    a_conflict_blocks: assert property (@(posedge clk) disable iff (reset)
        conflict && !mem.data_ok |=> !out_valid);

    // memory drops data_ok once the pair is taken
    a_accept_ok: assert property (@(posedge clk) disable iff (reset)
        mem.accept |-> mem.data_ok ##1 !mem.data_ok);

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter int IMEM_DEPTH  = 32,
    parameter int BPB_ENTRIES = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          exc_valid,
    input  logic [fetch_pkg::WORD_W-1:0]  exc_pc,
    input  logic                          eret,
    input  logic [fetch_pkg::WORD_W-1:0]  epc,
    input  logic                          branch_taken,
    input  logic [fetch_pkg::WORD_W-1:0]  branch_pc,
    input  logic                          jump,
    input  logic [fetch_pkg::WORD_W-1:0]  jump_pc,
    input  logic                          jr,
    input  logic [fetch_pkg::WORD_W-1:0]  jr_pc,
    input  logic                          bp_upd_valid,
    input  logic [fetch_pkg::WORD_W-1:0]  bp_upd_pc,
    input  logic                          bp_upd_taken,
    input  logic [fetch_pkg::WORD_W-1:0]  bp_upd_target,
    output logic [fetch_pkg::WORD_W-1:0]  pc,
    output logic                          out_valid,
    output logic [fetch_pkg::WORD_W-1:0]  slot_a_instr,
    output logic [fetch_pkg::WORD_W-1:0]  slot_a_pcplus4,
    output logic                          slot_a_pred,
    output logic                          slot_b_valid,
    output logic [fetch_pkg::WORD_W-1:0]  slot_b_instr,
    output logic [fetch_pkg::WORD_W-1:0]  slot_b_pcplus4,
    output logic                          slot_b_pred,
    output logic                          misaligned
);

    imem_if mem_bus ();
    bpb_if  bp_bus ();

    // resolved branches go straight to the predictor
    assign bp_bus.upd_valid  = bp_upd_valid;
    assign bp_bus.upd_pc     = bp_upd_pc;
    assign bp_bus.upd_taken  = bp_upd_taken;
    assign bp_bus.upd_target = bp_upd_target;

    imem_port #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem_port (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus)
    );

    branch_pred_buffer #(
        .BPB_ENTRIES (BPB_ENTRIES)
    ) u_bpb (
        .clk   (clk),
        .reset (reset),
        .bp    (bp_bus)
    );

    fetch_stage u_fetch_stage (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .exc_valid      (exc_valid),
        .exc_pc         (exc_pc),
        .eret           (eret),
        .epc            (epc),
        .branch_taken   (branch_taken),
        .branch_pc      (branch_pc),
        .jump           (jump),
        .jump_pc        (jump_pc),
        .jr             (jr),
        .jr_pc          (jr_pc),
        .mem            (mem_bus),
        .bp             (bp_bus),
        .pc             (pc),
        .out_valid      (out_valid),
        .slot_a_instr   (slot_a_instr),
        .slot_a_pcplus4 (slot_a_pcplus4),
        .slot_a_pred    (slot_a_pred),
        .slot_b_valid   (slot_b_valid),
        .slot_b_instr   (slot_b_instr),
        .slot_b_pcplus4 (slot_b_pcplus4),
        .slot_b_pred    (slot_b_pred),
        .misaligned     (misaligned)
    );

endmodule

// ==== imem.hex ====
// one 32-bit instruction word per line, word index 0 to 31
3c08bfc0
35080100
24090010
00000000
8d0a0000
01495021
11200003
00052880
2529ffff
ad0a0004
08000004
000a5040
3c02a000
24420020
0040f809
00c63021
03e00008
00e73821
240b0001
016b5820
15600002
01084021
42000018
01295021
8fbf0014
27bd0018
03e00009
014a5821
0c0000f0
24840004
1000ffff
016b6021

// ==== imem_if.sv ====
`timescale 1ns/1ps

interface imem_if;
    import fetch_pkg::*;

    // fetch side
    logic [WORD_W-1:0] addr;
    logic              accept;

    // memory side, held until accept
    logic [WORD_W-1:0] data_a;
    logic [WORD_W-1:0] data_b;
    logic              second_ok;
    logic              data_ok;

    modport fetcher (
        output addr,
        output accept,
        input  data_a,
        input  data_b,
        input  second_ok,
        input  data_ok
    );

    modport memory (
        input  addr,
        input  accept,
        output data_a,
        output data_b,
        output second_ok,
        output data_ok
    );

endinterface

// ==== imem_port.sv ====
`timescale 1ns/1ps

module imem_port #(
    parameter int IMEM_DEPTH = 32
) (
    input logic     clk,
    input logic     reset,
    imem_if.memory  mem
);
    import fetch_pkg::*;

    localparam int WORD_IDX_W = $clog2(IMEM_DEPTH);

    logic [WORD_W-1:0] rom [IMEM_DEPTH];

    logic                  launch;
    logic                  busy;
    logic [1:0]            wait_cnt;
    logic [WORD_W-1:0]     addr_q;
    logic [WORD_IDX_W-1:0] word_a;
    logic [WORD_IDX_W-1:0] word_b;

    initial
    begin
        $readmemh("imem.hex", rom);
    end

    // one request outstanding at a time
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            launch   <= 1'b1;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end
        else if (launch)
        begin
            launch   <= 1'b0;
            busy     <= 1'b1;
            wait_cnt <= mem.addr[4:3];
        end
        else if (busy && wait_cnt != 2'd0)
        begin
            wait_cnt <= wait_cnt - 2'd1;
        end
        else if (mem.data_ok && mem.accept)
        begin
            busy   <= 1'b0;
            launch <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
            addr_q <= mem.addr;
    end

    // word index wraps around the rom
    assign word_a = WORD_IDX_W'(addr_q[WORD_W-1:2] % IMEM_DEPTH);
    assign word_b = WORD_IDX_W'((addr_q[WORD_W-1:2] + 1'b1) % IMEM_DEPTH);

    assign mem.data_a    = rom[word_a];
    assign mem.data_b    = rom[word_b];
    assign mem.second_ok = ~addr_q[2];
    assign mem.data_ok   = busy && (wait_cnt == 2'd0);

    // response must not move until the fetch stage takes it
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        mem.data_ok && !mem.accept |=> mem.data_ok && $stable(mem.data_a)
            && $stable(mem.data_b) && $stable(mem.second_ok));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the fetch testbench under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_fetch_top -f verilog.f -o tb_fetch_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_fetch_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int IMEM_DEPTH      = 32;
    localparam int BPB_ENTRIES     = 16;
    localparam int SEED            = 66;
    localparam int RESET_CYCLES    = 8;
    localparam int SEQ_CYCLES      = 200;
    localparam int STALL_CYCLES    = 300;
    localparam int REDIRECT_ROUNDS = 24;
    localparam int ROUND_CYCLES    = 20;
    localparam int PRED_CYCLES     = 400;
    localparam int TEST_CYCLES     = RESET_CYCLES + SEQ_CYCLES + STALL_CYCLES
                                     + (REDIRECT_ROUNDS + 1) * ROUND_CYCLES + PRED_CYCLES;
    localparam int LATENCY_MARGIN  = 4;

    // one branch in slot a position and one in slot b position
    localparam logic [WORD_W-1:0] SLOT_A_BR  = 32'hbfc00010;
    localparam logic [WORD_W-1:0] SLOT_A_TGT = 32'hbfc00040;
    localparam logic [WORD_W-1:0] SLOT_B_BR  = 32'hbfc0004c;
    localparam logic [WORD_W-1:0] SLOT_B_TGT = 32'hbfc00080;

    logic              clk;
    logic              reset;
    logic              stall;
    logic              exc_valid;
    logic [WORD_W-1:0] exc_pc;
    logic              eret;
    logic [WORD_W-1:0] epc;
    logic              branch_taken;
    logic [WORD_W-1:0] branch_pc;
    logic              jump;
    logic [WORD_W-1:0] jump_pc;
    logic              jr;
    logic [WORD_W-1:0] jr_pc;
    logic              bp_upd_valid;
    logic [WORD_W-1:0] bp_upd_pc;
    logic              bp_upd_taken;
    logic [WORD_W-1:0] bp_upd_target;
    logic [WORD_W-1:0] pc;
    logic              out_valid;
    logic [WORD_W-1:0] slot_a_instr;
    logic [WORD_W-1:0] slot_a_pcplus4;
    logic              slot_a_pred;
    logic              slot_b_valid;
    logic [WORD_W-1:0] slot_b_instr;
    logic [WORD_W-1:0] slot_b_pcplus4;
    logic              slot_b_pred;
    logic              misaligned;

    // reference model state
    logic [WORD_W-1:0]      rom_copy [IMEM_DEPTH];
    logic [WORD_W-1:0]      exp_pc;
    logic [WORD_W-1:0]      exp_pc_b;
    logic                   exp_pred_taken;
    logic [WORD_W-1:0]      exp_pred_target;
    logic                   exp_conflict;
    logic                   exp_launch;
    logic                   exp_busy;
    logic [1:0]             exp_wait;
    logic [BPB_ENTRIES-1:0] tbl_valid;
    logic [25:0]            tbl_tag    [BPB_ENTRIES];
    logic [WORD_W-1:0]      tbl_target [BPB_ENTRIES];
    logic [CNT_W-1:0]       tbl_cnt    [BPB_ENTRIES];
    logic [3:0]             idx_a;
    logic [3:0]             idx_b;
    logic [3:0]             upd_idx;
    logic                   upd_hit;
    logic                   exp_a_pred;
    logic                   b_lookup_taken;
    logic                   exp_b_pred;
    logic                   exp_b_valid;
    logic                   exp_data_ok;
    logic                   exp_redirect;
    logic                   exp_out_valid;
    logic                   exp_accept;
    logic [WORD_W-1:0]      exp_redirect_pc;
    logic [WORD_W-1:0]      exp_next_pc;
    logic [WORD_W-1:0]      exp_a_word;
    logic [WORD_W-1:0]      exp_b_word;

    fetch_top #(
        .IMEM_DEPTH  (IMEM_DEPTH),
        .BPB_ENTRIES (BPB_ENTRIES)
    ) DUT (.*);

    // predictor mirror indexed by pc[5:2] with tag pc[31:6]
    assign exp_pc_b       = exp_pc + 32'd4;
    assign idx_a          = exp_pc[5:2];
    assign idx_b          = exp_pc_b[5:2];
    assign upd_idx        = bp_upd_pc[5:2];
    assign exp_a_pred     = tbl_valid[idx_a] && (tbl_tag[idx_a] == exp_pc[31:6])
                            && (tbl_cnt[idx_a] >= CNT_TAKEN_MIN);
    assign b_lookup_taken = tbl_valid[idx_b] && (tbl_tag[idx_b] == exp_pc_b[31:6])
                            && (tbl_cnt[idx_b] >= CNT_TAKEN_MIN);
    assign upd_hit        = tbl_valid[upd_idx] && (tbl_tag[upd_idx] == bp_upd_pc[31:6]);

    always_comb
    begin
        exp_data_ok = exp_busy && (exp_wait == 2'd0);
        exp_redirect = exc_valid || eret || branch_taken || jump || jr;
        if (exc_valid)
            exp_redirect_pc = exc_pc;
        else if (eret)
            exp_redirect_pc = epc;
        else if (branch_taken)
            exp_redirect_pc = branch_pc;
        else if (jump)
            exp_redirect_pc = jump_pc;
        else
            exp_redirect_pc = jr_pc;
        exp_out_valid = exp_data_ok && !exp_conflict && !stall && !exp_redirect;
        exp_accept    = exp_data_ok && (exp_conflict || (!stall && !exp_redirect));
        exp_b_valid   = !exp_pc[2] && !exp_pred_taken;
        exp_b_pred    = exp_b_valid && b_lookup_taken;
        // rom index wraps at 32 words
        exp_a_word    = rom_copy[exp_pc[6:2]];
        exp_b_word    = rom_copy[exp_pc_b[6:2]];
        if (exp_pred_taken)
            exp_next_pc = exp_pred_target;
        else if (exp_b_valid && exp_a_pred)
            exp_next_pc = tbl_target[idx_a];
        else if (exp_b_valid)
            exp_next_pc = exp_pc + 32'd8;
        else
            exp_next_pc = exp_pc + 32'd4;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            exp_pc          <= RESET_PC;
            exp_pred_taken  <= 1'b0;
            exp_pred_target <= '0;
            exp_conflict    <= 1'b0;
            exp_launch      <= 1'b1;
            exp_busy        <= 1'b0;
            exp_wait        <= 2'd0;
        end
        else
        begin
            // memory timing as seen from outside the port
            if (exp_launch)
            begin
                exp_launch <= 1'b0;
                exp_busy   <= 1'b1;
                exp_wait   <= exp_pc[4:3];
            end
            else if (exp_busy && exp_wait != 2'd0)
                exp_wait <= exp_wait - 2'd1;
            else if (exp_accept)
            begin
                exp_busy   <= 1'b0;
                exp_launch <= 1'b1;
            end

            if (exp_redirect)
            begin
                exp_pc         <= exp_redirect_pc;
                exp_pred_taken <= 1'b0;
                exp_conflict   <= !exp_accept;
            end
            else
            begin
                if (exp_out_valid)
                begin
                    exp_pc          <= exp_next_pc;
                    exp_pred_taken  <= exp_pred_taken ? 1'b0
                                       : (exp_b_valid ? b_lookup_taken : exp_a_pred);
                    exp_pred_target <= exp_b_valid ? tbl_target[idx_b] : tbl_target[idx_a];
                end
                if (exp_accept)
                    exp_conflict <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            tbl_valid <= '0;
        else if (bp_upd_valid)
        begin
            tbl_valid[upd_idx]  <= 1'b1;
            tbl_tag[upd_idx]    <= bp_upd_pc[31:6];
            tbl_target[upd_idx] <= bp_upd_target;
            if (!upd_hit)
                tbl_cnt[upd_idx] <= bp_upd_taken ? 2'd2 : 2'd1;
            else if (bp_upd_taken && tbl_cnt[upd_idx] != 2'd3)
                tbl_cnt[upd_idx] <= tbl_cnt[upd_idx] + 2'd1;
            else if (!bp_upd_taken && tbl_cnt[upd_idx] != 2'd0)
                tbl_cnt[upd_idx] <= tbl_cnt[upd_idx] - 2'd1;
        end
    end

    check_pc: assert property (@(posedge clk) disable iff (reset) pc == exp_pc)
        else report_mismatch("pc left the expected fetch sequence");
    check_out_valid: assert property (@(posedge clk) disable iff (reset)
        out_valid == exp_out_valid)
        else report_mismatch("out_valid differs from the expected response timing");
    check_stall: assert property (@(posedge clk) disable iff (reset) stall |-> !out_valid)
        else report_mismatch("out_valid high while stall is high");
    check_slot_a: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> slot_a_instr == exp_a_word && slot_a_pred == exp_a_pred)
        else report_mismatch("slot a word or prediction is wrong");
    check_slot_b: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> slot_b_instr == exp_b_word && slot_b_valid == exp_b_valid
            && slot_b_pred == exp_b_pred)
        else report_mismatch("slot b word, valid or prediction is wrong");
    check_pcplus: assert property (@(posedge clk) disable iff (reset)
        slot_a_pcplus4 == exp_pc + 32'd4 && slot_b_pcplus4 == exp_pc + 32'd8)
        else report_mismatch("slot pc plus values are wrong");
    check_misaligned: assert property (@(posedge clk) disable iff (reset)
        misaligned == (exp_pc[1:0] != 2'b00))
        else report_mismatch("misaligned flag does not follow pc");
    check_jr_misaligned: assert property (@(posedge clk) disable iff (reset)
        jr && !exc_valid && !eret && !branch_taken && !jump && jr_pc[1:0] != 2'b00
            |=> misaligned)
        else report_mismatch("jr to unaligned target left misaligned low");

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t ns: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic run_cycles(input int n, input int stall_pct);
        repeat (n)
        begin
            @(posedge clk);
            stall <= (($urandom % 100) < stall_pct);
        end
    endtask

    task automatic load_targets(input logic [WORD_W-1:0] base);
        exc_pc    <= base;
        epc       <= base ^ 32'h0000_0140;
        branch_pc <= base ^ 32'h0000_0284;
        jump_pc   <= base ^ 32'h0000_03c8;
        // low bits 2'b10 so never word aligned
        jr_pc     <= base ^ 32'h0000_0e0e;
    endtask

    // source bits exc eret branch jump jr from msb down
    task automatic fire_redirect(input logic [4:0] sources);
        @(posedge clk);
        exc_valid    <= sources[4];
        eret         <= sources[3];
        branch_taken <= sources[2];
        jump         <= sources[1];
        jr           <= sources[0];
        @(posedge clk);
        exc_valid    <= 1'b0;
        eret         <= 1'b0;
        branch_taken <= 1'b0;
        jump         <= 1'b0;
        jr           <= 1'b0;
    endtask

    task automatic drive_update(input logic [WORD_W-1:0] br_pc, input logic taken,
                                input logic [WORD_W-1:0] target);
        @(posedge clk);
        bp_upd_valid  <= 1'b1;
        bp_upd_pc     <= br_pc;
        bp_upd_taken  <= taken;
        bp_upd_target <= target;
        @(posedge clk);
        bp_upd_valid  <= 1'b0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        void'($urandom(SEED));
        reset         = 1'b1;
        stall         = 1'b0;
        exc_valid     = 1'b0;
        exc_pc        = '0;
        eret          = 1'b0;
        epc           = '0;
        branch_taken  = 1'b0;
        branch_pc     = '0;
        jump          = 1'b0;
        jump_pc       = '0;
        jr            = 1'b0;
        jr_pc         = '0;
        bp_upd_valid  = 1'b0;
        bp_upd_pc     = '0;
        bp_upd_taken  = 1'b0;
        bp_upd_target = '0;
        $readmemh("imem.hex", rom_copy);
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        run_cycles(SEQ_CYCLES, 0);
        run_cycles(STALL_CYCLES, 30);

        // several sources at once while a pair is in flight
        for (int r = 0; r < REDIRECT_ROUNDS; r++)
        begin
            run_cycles($urandom % 6, 20);
            load_targets({16'hbfc0, 14'($urandom), 2'b00});
            fire_redirect(5'($urandom % 31 + 1));
            run_cycles(ROUND_CYCLES - 8, 20);
        end

        run_cycles(3, 0);
        load_targets(32'hbfc00200);
        fire_redirect(5'b00001);
        run_cycles(ROUND_CYCLES, 0);

        // train both branches strongly taken then weaken one step per pass
        drive_update(SLOT_A_BR, 1'b1, SLOT_A_TGT);
        drive_update(SLOT_A_BR, 1'b1, SLOT_A_TGT);
        drive_update(SLOT_B_BR, 1'b1, SLOT_B_TGT);
        drive_update(SLOT_B_BR, 1'b1, SLOT_B_TGT);
        repeat (3)
        begin
            jump_pc <= RESET_PC;
            fire_redirect(5'b00010);
            run_cycles(100, 0);
            drive_update(SLOT_A_BR, 1'b0, SLOT_A_TGT);
            drive_update(SLOT_B_BR, 1'b0, SLOT_B_TGT);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

    initial
    begin
        repeat (TEST_CYCLES * LATENCY_MARGIN) @(posedge clk);
        $display("timeout after %0d cycles, the test sequence never finished",
                 TEST_CYCLES * LATENCY_MARGIN);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog.f ====
fetch_pkg.sv
imem_if.sv
bpb_if.sv
imem_port.sv
branch_pred_buffer.sv
fetch_stage.sv
fetch_top.sv
tb_fetch_top.sv
